//--- logic/decodePkg.sv
`default_nettype none

package decodePkg;

    typedef logic [31:0] instrT;
    typedef logic [63:0] immT;
    typedef logic [4:0]  regIdxT;
    typedef logic [5:0]  aluCtlT;     // {word/mul, opcode[3], op}
    typedef logic [1:0]  aluBSrcT;
    typedef logic [2:0]  branchT;
    typedef logic [2:0]  memOpT;      // same as funct3

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immFmtT;

    // major opcodes, instr[6:2]
    localparam logic [4:0] opLoad    = 5'b00000;
    localparam logic [4:0] opOpImm   = 5'b00100;
    localparam logic [4:0] opAuipc   = 5'b00101;
    localparam logic [4:0] opOpImm32 = 5'b00110;
    localparam logic [4:0] opStore   = 5'b01000;
    localparam logic [4:0] opOp      = 5'b01100;
    localparam logic [4:0] opLui     = 5'b01101;
    localparam logic [4:0] opOp32    = 5'b01110;
    localparam logic [4:0] opBranch  = 5'b11000;
    localparam logic [4:0] opJalr    = 5'b11001;
    localparam logic [4:0] opJal     = 5'b11011;
    localparam logic [4:0] opSystem  = 5'b11100;

    // operand B select
    localparam aluBSrcT bSrcRs2  = 2'd0;
    localparam aluBSrcT bSrcFour = 2'd1;
    localparam aluBSrcT bSrcImm  = 2'd2;

    // branch kinds
    localparam branchT brNone = 3'b000;
    localparam branchT brJal  = 3'b001;  // pc + imm
    localparam branchT brJalr = 3'b010;  // rs1 + imm
    localparam branchT brEq   = 3'b100;
    localparam branchT brNe   = 3'b101;
    localparam branchT brLt   = 3'b110;
    localparam branchT brGe   = 3'b111;

endpackage

`default_nettype wire

//--- logic/fetchQueue.sv
`default_nettype none

module fetchQueue import decodePkg::*; #(
    parameter int numLanes = 3,
    parameter int fqDepth  = 4
) (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire logic                instrValid,
    input  wire instrT               instr,
    input  wire logic [numLanes-1:0] laneBusy,
    output logic                     instrCredit,
    output logic [numLanes-1:0]      laneLoad,
    output instrT                    laneInstr
);

    localparam int fqPtrW   = (fqDepth > 1) ? $clog2(fqDepth) : 1;
    localparam int countW   = $clog2(fqDepth + 1);
    localparam int lanePtrW = (numLanes > 1) ? $clog2(numLanes) : 1;

    instrT               mem [fqDepth];
    logic [fqPtrW-1:0]   wrPtr;
    logic [fqPtrW-1:0]   rdPtr;
    logic [countW-1:0]   count;
    logic [lanePtrW-1:0] dispPtr;
    logic                doDispatch;

    assign doDispatch = (count != '0) && !laneBusy[dispPtr];
    assign laneLoad   = doDispatch ? (numLanes'(1) << dispPtr) : '0;
    assign laneInstr  = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (instrValid) begin
            mem[wrPtr] <= instr;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            count       <= '0;
            dispPtr     <= '0;
            instrCredit <= 1'b0;
        end else begin
            instrCredit <= doDispatch;  // one credit per freed entry
            count       <= count + countW'(instrValid) - countW'(doDispatch);
            if (instrValid) begin
                wrPtr <= (wrPtr == fqPtrW'(fqDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doDispatch) begin
                rdPtr   <= (rdPtr == fqPtrW'(fqDepth - 1)) ? '0 : rdPtr + 1'b1;
                dispPtr <= (dispPtr == lanePtrW'(numLanes - 1)) ? '0 : dispPtr + 1'b1;
            end
        end
    end

    // sender has to respect its credits
    noWriteWhenFull: assert property (
        @(posedge clk) disable iff (!rstN)
        instrValid |-> (count != countW'(fqDepth))
    );

endmodule

`default_nettype wire

//--- logic/ctrlDecode.sv
`default_nettype none

module ctrlDecode import decodePkg::*; (
    input  wire instrT instr,
    output immFmtT     immFmt,
    output aluCtlT     aluCtl,
    output logic       aluASrc,
    output aluBSrcT    aluBSrc,
    output branchT     branch,
    output logic       memRd,
    output logic       memWr,
    output logic       regWr,
    output memOpT      memOp,
    output logic       ebreak,
    output logic       illegal
);

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [3:0] aluOp;
    logic       wordOrMul;
    logic       err;

    assign opcode = instr[6:2];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign memOp   = funct3;
    assign memRd   = (opcode == opLoad);
    assign memWr   = (opcode == opStore);
    assign regWr   = (opcode != opBranch) && (opcode != opStore);
    assign aluASrc = (opcode == opAuipc) || (opcode == opJal) || (opcode == opJalr);  // pc
    assign ebreak  = (opcode == opSystem);

    assign wordOrMul = (opcode == opOp32) || (opcode == opOpImm32) ||
                       ((opcode == opOp) && funct7[0]);
    assign aluCtl  = {wordOrMul, instr[3], aluOp};
    assign illegal = err || (instr[1:0] != 2'b11);

    always_comb begin
        immFmt  = immI;
        aluBSrc = bSrcRs2;
        aluOp   = 4'b0000;
        branch  = brNone;
        err     = 1'b0;
        case (opcode)
            opSystem: begin
                aluBSrc = bSrcFour;
                branch  = brJal;
            end
            opLui: begin
                immFmt  = immU;
                aluBSrc = bSrcImm;
                aluOp   = 4'b1111;  // pass B
            end
            opAuipc: begin
                immFmt  = immU;
                aluBSrc = bSrcImm;
            end
            opJal: begin
                immFmt  = immJ;
                aluBSrc = bSrcFour;  // link = pc + 4
                branch  = brJal;
            end
            opJalr: begin
                aluBSrc = bSrcFour;
                branch  = brJalr;
                err     = (funct3 != 3'b000);
            end
            opBranch: begin
                immFmt = immB;
                aluOp  = funct3[1] ? 4'b0011 : 4'b0010;  // unsigned compare for bltu/bgeu
                case (funct3)
                    3'b000:         branch = brEq;
                    3'b001:         branch = brNe;
                    3'b100, 3'b110: branch = brLt;
                    3'b101, 3'b111: branch = brGe;
                    default: begin
                        aluOp = 4'b0000;
                        err   = 1'b1;
                    end
                endcase
            end
            opLoad: begin
                aluBSrc = bSrcImm;
                err     = (funct3 == 3'b111);
            end
            opStore: begin
                immFmt  = immS;
                aluBSrc = bSrcImm;
                err     = funct3[2];  // only sb..sd
            end
            opOpImm, opOpImm32: begin
                aluBSrc = bSrcImm;
                aluOp   = {funct7[5] && (funct3 == 3'b101), funct3};  // srai
                err     = (opcode == opOpImm) && (funct3[1:0] == 2'b01) &&
                          (funct7[6:1] != 6'b000000) && (funct7[6:1] != 6'b010000);
            end
            opOp, opOp32: begin
                aluOp = {funct7[5], funct3};
                err   = (opcode == opOp) && (funct7 != 7'b0000000) &&
                        (funct7 != 7'b0100000) && (funct7 != 7'b0000001);
            end
            default: err = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/immGen.sv
`default_nettype none

module immGen import decodePkg::*; (
    input  wire instrT  instr,
    input  wire immFmtT immFmt,
    output immT         imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immFmt)
            immS: imm = {{52{sign}}, instr[31:25], instr[11:7]};
            immB: imm = {{51{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            immU: imm = {{32{sign}}, instr[31:12], 12'b0};
            immJ: imm = {{43{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = {{52{sign}}, instr[31:20]};  // I format
        endcase
    end

endmodule

`default_nettype wire

//--- logic/decodeLane.sv
`default_nettype none

module decodeLane import decodePkg::*; (
    input  wire logic  clk,
    input  wire logic  rstN,
    input  wire logic  load,
    input  wire instrT loadInstr,
    input  wire logic  unload,
    output logic       busy,
    output regIdxT     rs1,
    output regIdxT     rs2,
    output regIdxT     rd,
    output immT        imm,
    output aluCtlT     aluCtl,
    output logic       aluASrc,
    output aluBSrcT    aluBSrc,
    output branchT     branch,
    output logic       memRd,
    output logic       memWr,
    output logic       regWr,
    output memOpT      memOp,
    output logic       ebreak,
    output logic       illegal
);

    instrT  held;
    immFmtT immFmt;

    always_ff @(posedge clk) begin
        if (load) begin
            held <= loadInstr;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;
        end else if (unload) begin
            busy <= 1'b0;
        end
    end

    assign rs1 = held[19:15];
    assign rs2 = held[24:20];
    assign rd  = held[11:7];

    ctrlDecode ctrl0 (
        .instr(held), .immFmt(immFmt), .aluCtl(aluCtl), .aluASrc(aluASrc),
        .aluBSrc(aluBSrc), .branch(branch), .memRd(memRd), .memWr(memWr),
        .regWr(regWr), .memOp(memOp), .ebreak(ebreak), .illegal(illegal)
    );

    immGen imm0 (
        .instr(held), .immFmt(immFmt), .imm(imm)
    );

    // queue must only fill a free lane
    noLoadWhenBusy: assert property (
        @(posedge clk) disable iff (!rstN) load |-> !busy
    );

endmodule

`default_nettype wire

//--- logic/uopIssue.sv
`default_nettype none

module uopIssue import decodePkg::*; #(
    parameter int numLanes   = 3,
    parameter int uopCredits = 4
) (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire logic                uopCredit,
    input  wire logic [numLanes-1:0] laneBusy,
    input  wire regIdxT              laneRs1 [numLanes],
    input  wire regIdxT              laneRs2 [numLanes],
    input  wire regIdxT              laneRd [numLanes],
    input  wire immT                 laneImm [numLanes],
    input  wire aluCtlT              laneAluCtl [numLanes],
    input  wire logic [numLanes-1:0] laneAluASrc,
    input  wire aluBSrcT             laneAluBSrc [numLanes],
    input  wire branchT              laneBranch [numLanes],
    input  wire logic [numLanes-1:0] laneMemRd,
    input  wire logic [numLanes-1:0] laneMemWr,
    input  wire memOpT               laneMemOp [numLanes],
    input  wire logic [numLanes-1:0] laneRegWr,
    input  wire logic [numLanes-1:0] laneEbreak,
    input  wire logic [numLanes-1:0] laneIllegal,
    output logic [numLanes-1:0]      laneRelease,
    output logic                     uopValid,
    output regIdxT                   uopRs1,
    output regIdxT                   uopRs2,
    output regIdxT                   uopRd,
    output immT                      uopImm,
    output aluCtlT                   uopAluCtl,
    output logic                     uopAluASrc,
    output aluBSrcT                  uopAluBSrc,
    output branchT                   uopBranch,
    output logic                     uopMemRd,
    output logic                     uopMemWr,
    output memOpT                    uopMemOp,
    output logic                     uopRegWr,
    output logic                     uopEbreak,
    output logic                     uopIllegal
);

    localparam int lanePtrW = (numLanes > 1) ? $clog2(numLanes) : 1;
    localparam int creditW  = $clog2(uopCredits + 1);

    logic [lanePtrW-1:0] drainPtr;
    logic [creditW-1:0]  credits;
    logic                take;

    assign take        = laneBusy[drainPtr] && (credits != '0);
    assign laneRelease = take ? (numLanes'(1) << drainPtr) : '0;

    // payload, only meaningful with uopValid
    always_ff @(posedge clk) begin
        if (take) begin
            uopRs1     <= laneRs1[drainPtr];
            uopRs2     <= laneRs2[drainPtr];
            uopRd      <= laneRd[drainPtr];
            uopImm     <= laneImm[drainPtr];
            uopAluCtl  <= laneAluCtl[drainPtr];
            uopAluASrc <= laneAluASrc[drainPtr];
            uopAluBSrc <= laneAluBSrc[drainPtr];
            uopBranch  <= laneBranch[drainPtr];
            uopMemRd   <= laneMemRd[drainPtr];
            uopMemWr   <= laneMemWr[drainPtr];
            uopMemOp   <= laneMemOp[drainPtr];
            uopRegWr   <= laneRegWr[drainPtr];
            uopEbreak  <= laneEbreak[drainPtr];
            uopIllegal <= laneIllegal[drainPtr];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            drainPtr <= '0;  // same start lane as dispatch
            credits  <= creditW'(uopCredits);
            uopValid <= 1'b0;
        end else begin
            uopValid <= take;
            credits  <= credits + creditW'(uopCredit) - creditW'(take);
            if (take) begin
                drainPtr <= (drainPtr == lanePtrW'(numLanes - 1)) ? '0 : drainPtr + 1'b1;
            end
        end
    end

    // downstream returns no more than it was granted
    creditNoOverflow: assert property (
        @(posedge clk) disable iff (!rstN)
        (uopCredit && !take) |-> (credits < creditW'(uopCredits))
    );

endmodule

`default_nettype wire

//--- logic/decodeFront.sv
`default_nettype none

module decodeFront import decodePkg::*; #(
    parameter int numLanes   = 3,
    parameter int fqDepth    = 4,
    parameter int uopCredits = 4
) (
    input  wire logic  clk,
    input  wire logic  rstN,
    input  wire logic  instrValid,
    input  wire instrT instr,
    input  wire logic  uopCredit,
    output logic       instrCredit,
    output logic       uopValid,
    output regIdxT     uopRs1,
    output regIdxT     uopRs2,
    output regIdxT     uopRd,
    output immT        uopImm,
    output aluCtlT     uopAluCtl,
    output logic       uopAluASrc,
    output aluBSrcT    uopAluBSrc,
    output branchT     uopBranch,
    output logic       uopMemRd,
    output logic       uopMemWr,
    output memOpT      uopMemOp,
    output logic       uopRegWr,
    output logic       uopEbreak,
    output logic       uopIllegal
);

    logic [numLanes-1:0] laneLoad;
    logic [numLanes-1:0] laneRelease;
    logic [numLanes-1:0] laneBusy;
    instrT               laneInstr;
    regIdxT              laneRs1 [numLanes];
    regIdxT              laneRs2 [numLanes];
    regIdxT              laneRd [numLanes];
    immT                 laneImm [numLanes];
    aluCtlT              laneAluCtl [numLanes];
    aluBSrcT             laneAluBSrc [numLanes];
    branchT              laneBranch [numLanes];
    memOpT               laneMemOp [numLanes];
    logic [numLanes-1:0] laneAluASrc;
    logic [numLanes-1:0] laneMemRd;
    logic [numLanes-1:0] laneMemWr;
    logic [numLanes-1:0] laneRegWr;
    logic [numLanes-1:0] laneEbreak;
    logic [numLanes-1:0] laneIllegal;

    fetchQueue #(.numLanes(numLanes), .fqDepth(fqDepth)) fq0 (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .laneBusy(laneBusy), .instrCredit(instrCredit), .laneLoad(laneLoad),
        .laneInstr(laneInstr)
    );

    for (genvar g = 0; g < numLanes; g++) begin : genLane
        decodeLane lane (
            .clk(clk), .rstN(rstN), .load(laneLoad[g]), .loadInstr(laneInstr),
            .unload(laneRelease[g]), .busy(laneBusy[g]), .rs1(laneRs1[g]),
            .rs2(laneRs2[g]), .rd(laneRd[g]), .imm(laneImm[g]), .aluCtl(laneAluCtl[g]),
            .aluASrc(laneAluASrc[g]), .aluBSrc(laneAluBSrc[g]), .branch(laneBranch[g]),
            .memRd(laneMemRd[g]), .memWr(laneMemWr[g]), .regWr(laneRegWr[g]),
            .memOp(laneMemOp[g]), .ebreak(laneEbreak[g]), .illegal(laneIllegal[g])
        );
    end

    uopIssue #(.numLanes(numLanes), .uopCredits(uopCredits)) issue0 (
        .clk(clk), .rstN(rstN), .uopCredit(uopCredit), .laneBusy(laneBusy),
        .laneRs1(laneRs1), .laneRs2(laneRs2), .laneRd(laneRd), .laneImm(laneImm),
        .laneAluCtl(laneAluCtl), .laneAluASrc(laneAluASrc), .laneAluBSrc(laneAluBSrc),
        .laneBranch(laneBranch), .laneMemRd(laneMemRd), .laneMemWr(laneMemWr),
        .laneMemOp(laneMemOp), .laneRegWr(laneRegWr), .laneEbreak(laneEbreak),
        .laneIllegal(laneIllegal), .laneRelease(laneRelease), .uopValid(uopValid),
        .uopRs1(uopRs1), .uopRs2(uopRs2), .uopRd(uopRd), .uopImm(uopImm),
        .uopAluCtl(uopAluCtl), .uopAluASrc(uopAluASrc), .uopAluBSrc(uopAluBSrc),
        .uopBranch(uopBranch), .uopMemRd(uopMemRd), .uopMemWr(uopMemWr),
        .uopMemOp(uopMemOp), .uopRegWr(uopRegWr), .uopEbreak(uopEbreak),
        .uopIllegal(uopIllegal)
    );

endmodule

`default_nettype wire

//--- sim/tbClock.sv
`default_nettype none

module tbClock (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;
    always #2 clk = ~clk;  // 4 ns period

    initial begin
        rstN = 1'b0;
        repeat (8) @(posedge clk);
        #1 rstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/decodeFrontTb.sv
`default_nettype none

module decodeFrontTb import decodePkg::*; ;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int numLanes   = 3;
    localparam int fqDepth    = 4;
    localparam int uopCredits = 4;
    localparam int waitLimit  = 300;

    typedef struct packed {
        regIdxT  rs1;
        regIdxT  rs2;
        regIdxT  rd;
        immT     imm;
        aluCtlT  aluCtl;
        logic    aluASrc;
        aluBSrcT aluBSrc;
        branchT  branch;
        logic    memRd;
        logic    memWr;
        memOpT   memOp;
        logic    regWr;
        logic    ebreak;
        logic    illegal;
    } uopT;

    logic clk, rstN, instrValid, uopCredit, instrCredit, uopValid;
    instrT instr;
    regIdxT uopRs1, uopRs2, uopRd;
    immT uopImm;
    aluCtlT uopAluCtl;
    logic uopAluASrc, uopMemRd, uopMemWr, uopRegWr, uopEbreak, uopIllegal;
    aluBSrcT uopAluBSrc;
    branchT uopBranch;
    memOpT uopMemOp;

    int          senderCredits = fqDepth;
    int          creditPulses  = 0;
    int          owed          = 0;
    logic        rxEnable      = 1'b0;
    logic [31:0] rngState      = 32'h9b2e_1029;
    instrT       expQ [$];
    uopT         gotQ [$];

    tbClock clkGen (.clk(clk), .rstN(rstN));

    decodeFront dut0 (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .uopCredit(uopCredit), .instrCredit(instrCredit), .uopValid(uopValid),
        .uopRs1(uopRs1), .uopRs2(uopRs2), .uopRd(uopRd), .uopImm(uopImm),
        .uopAluCtl(uopAluCtl), .uopAluASrc(uopAluASrc), .uopAluBSrc(uopAluBSrc),
        .uopBranch(uopBranch), .uopMemRd(uopMemRd), .uopMemWr(uopMemWr),
        .uopMemOp(uopMemOp), .uopRegWr(uopRegWr), .uopEbreak(uopEbreak),
        .uopIllegal(uopIllegal)
    );

    task automatic reportMismatch(input string msg);
        $display("mismatch at %0d ns: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic abortOnTimeout(input string what);
        $display("timed out at %0d ns while waiting for %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic instrT iType(logic [11:0] imm, regIdxT rs1, logic [2:0] f3,
                                    regIdxT rd, logic [4:0] opc);
        return {imm, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic instrT sType(logic [11:0] imm, regIdxT rs2, regIdxT rs1,
                                    logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore, 2'b11};
    endfunction

    function automatic instrT bType(logic [12:0] imm, regIdxT rs2, regIdxT rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch, 2'b11};
    endfunction

    function automatic instrT uType(logic [19:0] imm, regIdxT rd, logic [4:0] opc);
        return {imm, rd, opc, 2'b11};
    endfunction

    function automatic instrT jType(logic [20:0] imm, regIdxT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal, 2'b11};
    endfunction

    function automatic instrT rType(logic [6:0] f7, regIdxT rs2, regIdxT rs1,
                                    logic [2:0] f3, regIdxT rd, logic [4:0] opc);
        return {f7, rs2, rs1, f3, rd, opc, 2'b11};
    endfunction

    // expected micro-op straight from the ISA field layout
    function automatic uopT refDecode(instrT i);
        uopT u;
        logic [4:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic s;
        opc = i[6:2];
        f3  = i[14:12];
        f7  = i[31:25];
        s   = i[31];
        u = '0;
        u.rs1 = i[19:15];
        u.rs2 = i[24:20];
        u.rd  = i[11:7];
        case (opc)
            opStore:        u.imm = {{52{s}}, i[31:25], i[11:7]};
            opBranch:       u.imm = {{52{s}}, i[7], i[30:25], i[11:8], 1'b0};
            opLui, opAuipc: u.imm = {{32{s}}, i[31:12], 12'h000};
            opJal:          u.imm = {{44{s}}, i[19:12], i[20], i[30:21], 1'b0};
            default:        u.imm = {{52{s}}, i[31:20]};
        endcase
        u.memOp   = f3;
        u.memRd   = (opc == opLoad);
        u.memWr   = (opc == opStore);
        u.regWr   = !(opc == opBranch || opc == opStore);
        u.aluASrc = (opc == opAuipc || opc == opJal || opc == opJalr);
        u.ebreak  = (opc == opSystem);
        if (opc == opJal || opc == opJalr || opc == opSystem) u.aluBSrc = 2'd1;
        else if (opc == opOp || opc == opOp32 || opc == opBranch) u.aluBSrc = 2'd0;
        else u.aluBSrc = 2'd2;
        case (opc)
            opJal, opSystem: u.branch = 3'b001;
            opJalr:          u.branch = 3'b010;
            opBranch:        u.branch = (f3[2]) ? {2'b11, f3[0]} : {2'b10, f3[0]};
            default:         u.branch = 3'b000;
        endcase
        u.aluCtl[5] = (opc == opOp32 || opc == opOpImm32 || (opc == opOp && f7[0]));
        u.aluCtl[4] = i[3];
        u.aluCtl[2:0] = f3;
        u.aluCtl[3] = f7[5] && (opc == opOp || opc == opOp32 || f3 == 3'b101);
        u.illegal = (i[1:0] != 2'b11) ||
            !(opc inside {opLoad, opOpImm, opAuipc, opOpImm32, opStore, opOp, opLui,
                          opOp32, opBranch, opJalr, opJal, opSystem}) ||
            (opc == opBranch && f3[2:1] == 2'b01) ||
            (opc == opLoad && f3 == 3'b111) ||
            (opc == opStore && f3 > 3'b011) ||
            (opc == opJalr && f3 != 3'b000) ||
            (opc == opOp && !(f7 inside {7'b0000000, 7'b0100000, 7'b0000001})) ||
            (opc == opOpImm && f3[1:0] == 2'b01 && !(f7[6:1] inside {6'b000000, 6'b010000}));
        return u;
    endfunction

    // op bits of aluCtl only carry meaning for ALU instructions
    function automatic aluCtlT aluMask(instrT i);
        logic [4:0] opc;
        opc = i[6:2];
        if (opc == opOp || opc == opOp32) return 6'b111111;
        if (opc == opOpImm || opc == opOpImm32)
            return (i[14:12] == 3'b101) ? 6'b111111 : 6'b110111;
        return 6'b110000;
    endfunction

    task automatic checkField(input string name, input instrT i,
                              input logic [63:0] got, input logic [63:0] exp);
        assert (got == exp) else
            reportMismatch($sformatf("%s of %h is %h, expected %h", name, i, got, exp));
    endtask

    task automatic compareUop(input instrT i, input uopT got);
        uopT exp;
        aluCtlT m;
        exp = refDecode(i);
        m = aluMask(i);
        checkField("illegal", i, 64'(got.illegal), 64'(exp.illegal));
        checkField("ebreak", i, 64'(got.ebreak), 64'(exp.ebreak));
        if (!exp.illegal) begin
            checkField("rs1", i, 64'(got.rs1), 64'(exp.rs1));
            checkField("rs2", i, 64'(got.rs2), 64'(exp.rs2));
            checkField("rd", i, 64'(got.rd), 64'(exp.rd));
            checkField("imm", i, got.imm, exp.imm);
            checkField("aluCtl", i, 64'(got.aluCtl & m), 64'(exp.aluCtl & m));
            checkField("aluASrc", i, 64'(got.aluASrc), 64'(exp.aluASrc));
            checkField("aluBSrc", i, 64'(got.aluBSrc), 64'(exp.aluBSrc));
            checkField("branch", i, 64'(got.branch), 64'(exp.branch));
            checkField("memRd", i, 64'(got.memRd), 64'(exp.memRd));
            checkField("memWr", i, 64'(got.memWr), 64'(exp.memWr));
            checkField("memOp", i, 64'(got.memOp), 64'(exp.memOp));
            checkField("regWr", i, 64'(got.regWr), 64'(exp.regWr));
        end
    endtask

    // upstream credits come back one per pulse
    always @(posedge clk) begin
        if (rstN && instrCredit) begin
            senderCredits++;
            creditPulses++;
        end
    end

    task automatic collectUop();
        uopT u;
        if (rstN && uopValid) begin
            u = '{uopRs1, uopRs2, uopRd, uopImm, uopAluCtl, uopAluASrc, uopAluBSrc,
                  uopBranch, uopMemRd, uopMemWr, uopMemOp, uopRegWr, uopEbreak, uopIllegal};
            gotQ.push_back(u);
            owed++;
        end
        #1;
        if (rxEnable && owed > 0) begin
            uopCredit = 1'b1;
            owed--;
        end else begin
            uopCredit = 1'b0;
        end
    endtask

    always @(posedge clk) collectUop();

    task automatic sendInstr(input instrT i);
        int n;
        n = 0;
        while (senderCredits == 0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > waitLimit) abortOnTimeout("an upstream credit");
        end
        instrValid = 1'b1;
        instr = i;
        senderCredits--;
        expQ.push_back(i);
        @(posedge clk);
        #1;
        instrValid = 1'b0;
    endtask

    task automatic drainAndCheck();
        int n;
        n = 0;
        while (gotQ.size() < expQ.size()) begin
            @(posedge clk);
            n++;
            if (n > waitLimit) abortOnTimeout("micro-ops");
        end
        repeat (10) @(posedge clk);  // catch extra micro-ops
        #1;
        assert (gotQ.size() == expQ.size()) else
            reportMismatch($sformatf("got %0d micro-ops, sent %0d", gotQ.size(), expQ.size()));
        while (expQ.size() > 0) compareUop(expQ.pop_front(), gotQ.pop_front());
    endtask

    function automatic instrT randomLegal();
        logic [31:0] a, b, c;
        logic [2:0] f3;
        logic [6:0] f7;
        a = nextRand();
        b = nextRand();
        c = nextRand();
        f3 = a[14:12];
        f7 = (b[1:0] == 2'd0) ? 7'b0000000 : (b[1:0] == 2'd1) ? 7'b0100000 : 7'b0000001;
        case (c % 11)
            0: return iType(b[11:0], a[19:15], (f3 == 3'b111) ? 3'b011 : f3, a[11:7], opLoad);
            1: return sType(b[11:0], a[24:20], a[19:15], {1'b0, f3[1:0]});
            2: return bType({b[12:1], 1'b0}, a[24:20], a[19:15],
                            (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3);
            3: return jType({b[20:1], 1'b0}, a[11:7]);
            4: return iType(b[11:0], a[19:15], 3'b000, a[11:7], opJalr);
            5: return uType(b[19:0], a[11:7], opLui);
            6: return uType(b[19:0], a[11:7], opAuipc);
            7: return rType(f7, a[24:20], a[19:15], f3, a[11:7], opOp);
            8: return rType(f7, a[24:20], a[19:15], f3, a[11:7], opOp32);
            9: begin
                if (f3[1:0] == 2'b01)
                    return iType({b[0] ? 6'b010000 : 6'b000000, b[7:2]}, a[19:15], f3,
                                 a[11:7], opOpImm);
                return iType(b[11:0], a[19:15], f3, a[11:7], opOpImm);
            end
            default: return iType(b[11:0], a[19:15], f3, a[11:7], opOpImm32);
        endcase
    endfunction

    task automatic backPressureTest();
        int sent, idle;
        sent = 0;
        idle = 0;
        while (idle < 20) begin
            if (senderCredits > 0) begin
                sendInstr(randomLegal());
                sent++;
                idle = 0;
                assert (sent <= numLanes + fqDepth + uopCredits) else
                    reportMismatch($sformatf("sender still has credits after %0d", sent));
            end else begin
                @(posedge clk);
                #1;
                idle++;
            end
        end
        assert (gotQ.size() == uopCredits) else
            reportMismatch($sformatf("%0d micro-ops without credit return", gotQ.size()));
        rxEnable = 1'b1;
        drainAndCheck();
        idle = 0;
        while (creditPulses < sent) begin
            @(posedge clk);
            #1;
            idle++;
            if (idle > waitLimit) abortOnTimeout("all instrCredit pulses");
        end
        assert (creditPulses == sent) else
            reportMismatch($sformatf("%0d instrCredit pulses for %0d instructions",
                                     creditPulses, sent));
    endtask

    task automatic immediatesTest();
        sendInstr(iType(12'hffb, 5'd3, 3'b000, 5'd7, opOpImm));
        sendInstr(iType(12'h064, 5'd31, 3'b000, 5'd1, opOpImm));
        sendInstr(sType(12'h800, 5'd9, 5'd2, 3'b010));
        sendInstr(sType(12'h07f, 5'd17, 5'd30, 3'b010));
        sendInstr(bType(13'h1ff0, 5'd5, 5'd6, 3'b000));
        sendInstr(bType(13'h0040, 5'd11, 5'd12, 3'b000));
        sendInstr(uType(20'hfffff, 5'd20, opLui));
        sendInstr(uType(20'h12345, 5'd21, opLui));
        sendInstr(jType(21'h1ffffc, 5'd1));
        sendInstr(jType(21'h000800, 5'd0));
        drainAndCheck();
    endtask

    task automatic controlTest();
        sendInstr(iType(12'h010, 5'd1, 3'b010, 5'd2, opLoad));
        sendInstr(iType(12'hff0, 5'd1, 3'b100, 5'd2, opLoad));
        sendInstr(sType(12'h008, 5'd3, 5'd4, 3'b011));
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) sendInstr(bType(13'h0010, 5'd7, 5'd8, 3'(f)));
        end
        sendInstr(jType(21'h000100, 5'd1));
        sendInstr(iType(12'h004, 5'd5, 3'b000, 5'd1, opJalr));
        sendInstr(uType(20'h00abc, 5'd9, opAuipc));
        sendInstr(rType(7'b0000000, 5'd1, 5'd2, 3'b000, 5'd3, opOp));
        sendInstr(rType(7'b0100000, 5'd1, 5'd2, 3'b000, 5'd3, opOp));
        sendInstr(rType(7'b0000001, 5'd1, 5'd2, 3'b100, 5'd3, opOp));
        sendInstr(rType(7'b0000001, 5'd1, 5'd2, 3'b000, 5'd3, opOp32));
        sendInstr(iType(12'h01f, 5'd4, 3'b001, 5'd5, opOpImm));
        sendInstr(iType(12'h03f, 5'd4, 3'b101, 5'd5, opOpImm));
        sendInstr(iType(12'h405, 5'd4, 3'b101, 5'd5, opOpImm));
        drainAndCheck();
    endtask

    task automatic illegalTest();
        uopT r;
        sendInstr(32'h0000_0010);  // addi with low bits 00
        sendInstr(32'h0000_000b);  // custom opcode
        sendInstr(bType(13'h0010, 5'd1, 5'd2, 3'b010));
        sendInstr(iType(12'h000, 5'd1, 3'b111, 5'd2, opLoad));
        sendInstr(sType(12'h000, 5'd1, 5'd2, 3'b100));
        sendInstr(iType(12'h000, 5'd1, 3'b001, 5'd2, opJalr));
        sendInstr(rType(7'b0000010, 5'd1, 5'd2, 3'b000, 5'd3, opOp));
        sendInstr(32'h0010_0073);  // ebreak
        for (int k = 0; k < 8; k++) begin
            r = refDecode(expQ[k]);
            assert (r.illegal == (k < 7)) else
                reportMismatch($sformatf("reference illegal wrong for %h", expQ[k]));
        end
        drainAndCheck();
    endtask

    task automatic orderTest();
        for (int k = 0; k < 40; k++) sendInstr(randomLegal());
        drainAndCheck();
    endtask

    initial begin
        int n;
        instrValid = 1'b0;
        instr = '0;
        uopCredit = 1'b0;
        n = 0;
        while (rstN !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 50) abortOnTimeout("reset release");
        end
        @(posedge clk);
        #1;
        backPressureTest();  // needs fresh reset credits
        immediatesTest();
        controlTest();
        illegalTest();
        orderTest();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
logic/decodePkg.sv
logic/fetchQueue.sv
logic/ctrlDecode.sv
logic/immGen.sv
logic/decodeLane.sv
logic/uopIssue.sv
logic/decodeFront.sv
sim/tbClock.sv
sim/decodeFrontTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= decodeFrontTb
RTL_TOP   ?= decodeFront
FLIST     ?= project.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: build
	@out=$$(./$(OBJDIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/100ps -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)
